// ==== vmem_types_pkg.sv ====
`default_nettype none

package vmem_types_pkg;

  // Vector register length in bytes
  localparam int unsigned VLENB = 8;

  // Element width codes, same encoding as vtype.vsew
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // Register grouping codes
  typedef enum logic [2:0] {
    LMUL_1  = 3'b000,
    LMUL_2  = 3'b001,
    LMUL_4  = 3'b010,
    LMUL_8  = 3'b011,
    LMUL_F8 = 3'b101,
    LMUL_F4 = 3'b110,
    LMUL_F2 = 3'b111
  } vlmul_t;

  // Low bits of vtype, upper bits read as zero
  typedef struct packed {
    sew_t   sew;
    vlmul_t vlmul;
  } vtype_t;

endpackage

`default_nettype wire

// ==== vmem_pipe_pkg.sv ====
`default_nettype none

package vmem_pipe_pkg;

  // Instruction class seen by the memory stage
  typedef enum logic [1:0] {
    VOP_ALU    = 2'd0,
    VOP_LOAD   = 2'd1,
    VOP_STORE  = 2'd2,
    VOP_CONFIG = 2'd3
  } vop_t;

  // Execute to memory latch contents
  typedef struct packed {
    vop_t                  op;
    vmem_types_pkg::sew_t  eew;
    // Lane addresses for loads and stores
    logic [31:0]           result0;
    logic [31:0]           result1;
    logic [31:0]           storedata0;
    logic [31:0]           storedata1;
    logic [1:0]            wen;
    logic [4:0]            vd;
    logic [31:0]           next_vl;
    vmem_types_pkg::vtype_t next_vtype;
  } ex_mem_t;

  // Memory to writeback latch contents
  typedef struct packed {
    logic                   valid;
    logic [31:0]            wdat0;
    logic [31:0]            wdat1;
    logic [1:0]             wen;
    logic [4:0]             vd;
    vmem_types_pkg::sew_t   sew;
    vmem_types_pkg::vlmul_t lmul;
    logic [31:0]            vl;
  } mem_wb_t;

  // Data memory request, word addressed
  typedef struct packed {
    logic        ren;
    logic        wen;
    logic [29:0] addr;
    logic [3:0]  byte_ena;
    logic [31:0] wdata;
  } dmem_req_t;

endpackage

`default_nettype wire

// ==== vmem_store_format.sv ====
`timescale 1ns/100ps
`default_nettype none

module vmem_store_format (
  input  vmem_types_pkg::sew_t  eew,
  input  logic [1:0]            addr0,
  input  logic [1:0]            addr1,
  input  logic [31:0]           storedata0,
  input  logic [31:0]           storedata1,
  output logic [31:0]           fmt_data0,
  output logic [31:0]           fmt_data1,
  output logic [3:0]            fmt_be0,
  output logic [3:0]            fmt_be1,
  output logic [1:0]            misalign
);

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  be;
    logic        misalign;
  } lane_fmt_t;

  lane_fmt_t lane0;
  lane_fmt_t lane1;

  // Replicate the element so any byte offset finds it in place
  function automatic lane_fmt_t format_lane(input vmem_types_pkg::sew_t w,
                                            input logic [1:0] off,
                                            input logic [31:0] sd);
    lane_fmt_t f;
    f = '0;
    case (w)
      vmem_types_pkg::SEW8: begin
        f.data = {4{sd[7:0]}};
        f.be   = 4'b0001 << off;
      end
      vmem_types_pkg::SEW16: begin
        f.data     = {2{sd[15:0]}};
        f.be       = off[1] ? 4'b1100 : 4'b0011;
        f.misalign = off[0];
      end
      default: begin
        f.data     = sd;
        f.be       = 4'b1111;
        f.misalign = |off;
      end
    endcase
    return f;
  endfunction

  assign lane0 = format_lane(eew, addr0, storedata0);
  assign lane1 = format_lane(eew, addr1, storedata1);

  assign fmt_data0 = lane0.data;
  assign fmt_data1 = lane1.data;
  assign fmt_be0   = lane0.be;
  assign fmt_be1   = lane1.be;
  assign misalign  = {lane1.misalign, lane0.misalign};

endmodule

`default_nettype wire

// ==== vmem_load_align.sv ====
`timescale 1ns/100ps
`default_nettype none

module vmem_load_align (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic [31:0]           rdata,
  input  logic                  load_lane0,
  input  logic                  load_lane1,
  input  vmem_types_pkg::sew_t  eew,
  input  logic [1:0]            addr0,
  input  logic [1:0]            addr1,
  output logic [31:0]           ldata0,
  output logic [31:0]           ldata1
);

  logic [31:0] lane_buf0;
  logic [31:0] lane_buf1;

  // Shift the element down to bit 0 and zero extend
  function automatic logic [31:0] extract(input logic [31:0] word,
                                          input logic [1:0] off,
                                          input vmem_types_pkg::sew_t w);
    logic [31:0] sh;
    sh = word >> {off, 3'b000};
    case (w)
      vmem_types_pkg::SEW8:  return {24'd0, sh[7:0]};
      vmem_types_pkg::SEW16: return {16'd0, sh[15:0]};
      default:               return sh;
    endcase
  endfunction

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lane_buf0 <= '0;
      lane_buf1 <= '0;
    end else begin
      if (load_lane0) begin
        lane_buf0 <= rdata;
      end
      if (load_lane1) begin
        lane_buf1 <= rdata;
      end
    end
  end

  // Bypass the buffer in the capture cycle
  assign ldata0 = extract(load_lane0 ? rdata : lane_buf0, addr0, eew);
  assign ldata1 = extract(load_lane1 ? rdata : lane_buf1, addr1, eew);

endmodule

`default_nettype wire

// ==== vmem_addr_scheduler.sv ====
`timescale 1ns/100ps
`default_nettype none

module vmem_addr_scheduler (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      ex_valid,
  input  vmem_pipe_pkg::ex_mem_t    ex_in,
  input  logic                      flush,
  input  logic [31:0]               vl,
  input  logic [1:0]                misalign,
  input  logic [31:0]               fmt_data0,
  input  logic [31:0]               fmt_data1,
  input  logic [3:0]                fmt_be0,
  input  logic [3:0]                fmt_be1,
  output vmem_pipe_pkg::dmem_req_t  dmem_req,
  output vmem_pipe_pkg::ex_mem_t    mem_inst,
  output logic [1:0]                mem_wen,
  output logic                      load_lane0,
  output logic                      load_lane1,
  output logic                      wb_load,
  output logic                      busy,
  output logic                      exception
);

  typedef enum logic [2:0] {
    IDLE,
    LANE0,
    LANE1,
    WAIT,
    DONE
  } state_t;

  state_t state;
  state_t next_state;
  logic   lane1_act;
  logic   mem_start;
  logic   is_load;
  logic   is_store;
  logic   req_slot;
  logic   lane_sel;

  assign mem_start = ex_valid && (ex_in.op == vmem_pipe_pkg::VOP_LOAD ||
                                  ex_in.op == vmem_pipe_pkg::VOP_STORE);
  assign is_load   = (mem_inst.op == vmem_pipe_pkg::VOP_LOAD);
  assign is_store  = (mem_inst.op == vmem_pipe_pkg::VOP_STORE);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= IDLE;
      lane1_act <= 1'b0;
    end else begin
      state <= next_state;
      // Lane 1 takes part only when vl covers it
      if (state == IDLE && mem_start) begin
        lane1_act <= (vl >= 32'd2);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (state == IDLE && mem_start) begin
      mem_inst <= ex_in;
    end
  end

  // Fixed length sequence, WAIT fills the lane 1 slot when it is inactive
  always_comb begin
    next_state = state;
    case (state)
      IDLE:        if (mem_start) next_state = LANE0;
      LANE0:       next_state = lane1_act ? LANE1 : WAIT;
      LANE1, WAIT: next_state = DONE;
      DONE:        next_state = IDLE;
      default:     next_state = IDLE;
    endcase
    if (flush) begin
      next_state = IDLE;
    end
  end

  assign req_slot = (state == LANE0) || (state == LANE1);
  assign lane_sel = (state == LANE1);

  always_comb begin
    dmem_req  = '0;
    exception = 1'b0;
    if (req_slot) begin
      if (misalign[lane_sel]) begin
        // No access, flag the lane instead
        exception = 1'b1;
      end else begin
        dmem_req.ren      = is_load;
        dmem_req.wen      = is_store;
        dmem_req.addr     = lane_sel ? mem_inst.result1[31:2] : mem_inst.result0[31:2];
        dmem_req.byte_ena = lane_sel ? fmt_be1 : fmt_be0;
        dmem_req.wdata    = lane_sel ? fmt_data1 : fmt_data0;
      end
    end
  end

  // RAM data shows up one cycle after each request
  assign load_lane0 = is_load && (state == LANE1 || state == WAIT);
  assign load_lane1 = is_load && lane1_act && (state == DONE);
  assign wb_load    = (state == DONE);
  assign busy       = (state != IDLE);

  // Register write enables for the load result
  assign mem_wen = is_load ? (mem_inst.wen & {lane1_act & ~misalign[1], ~misalign[0]})
                           : 2'b00;

endmodule

`default_nettype wire

// ==== vmem_csr_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module vmem_csr_regs (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    ex_valid,
  input  vmem_pipe_pkg::ex_mem_t  ex_in,
  output logic [31:0]             vl,
  output vmem_types_pkg::vtype_t  vtype,
  output logic [31:0]             vstart
);

  // Two element lanes in this datapath
  localparam int unsigned LANES = 2;

  logic        cfg;
  logic [31:0] vlmax;
  logic [31:0] new_vl;

  assign cfg = ex_valid && (ex_in.op == vmem_pipe_pkg::VOP_CONFIG);

  // Elements per register at the new SEW, then the lane limit
  always_comb begin
    vlmax = 32'(vmem_types_pkg::VLENB) >> ex_in.next_vtype.sew;
    if (vlmax > 32'(LANES)) begin
      vlmax = 32'(LANES);
    end
    new_vl = (ex_in.next_vl > vlmax) ? vlmax : ex_in.next_vl;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      vl     <= '0;
      vtype  <= '0;
      vstart <= '0;
    end else if (cfg) begin
      vl     <= new_vl;
      vtype  <= ex_in.next_vtype;
      vstart <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== vmem_data_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module vmem_data_ram #(
  parameter int ADDR_W     = 10,
  parameter int DMEM_WORDS = 256
) (
  input  logic                      CLK,
  input  logic                      nRST,
  input  vmem_pipe_pkg::dmem_req_t  dmem_req,
  output logic [31:0]               rdata,
  output logic                      dhit
);

  logic [31:0]       mem [DMEM_WORDS];
  logic [ADDR_W-3:0] idx;

  // Byte address bits above the word offset
  assign idx = dmem_req.addr[ADDR_W-3:0];

  always_ff @(posedge CLK) begin
    if (dmem_req.wen) begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_req.byte_ena[i]) begin
          mem[idx][8*i +: 8] <= dmem_req.wdata[8*i +: 8];
        end
      end
    end
    if (dmem_req.ren) begin
      rdata <= mem[idx];
    end
  end

  // One-cycle response strobe
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dhit <= 1'b0;
    end else begin
      dhit <= dmem_req.ren | dmem_req.wen;
    end
  end

endmodule

`default_nettype wire

// ==== vmem_wb_latch.sv ====
`timescale 1ns/100ps
`default_nettype none

module vmem_wb_latch (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    flush,
  input  logic                    ex_valid,
  input  vmem_pipe_pkg::ex_mem_t  ex_in,
  input  logic                    wb_load,
  input  logic [31:0]             ldata0,
  input  logic [31:0]             ldata1,
  input  logic [1:0]              mem_wen,
  input  logic [31:0]             vl,
  input  vmem_types_pkg::vtype_t  vtype,
  output vmem_pipe_pkg::mem_wb_t  wb_out
);

  logic        pass_take;
  logic        mem_take;
  logic        valid_q;
  logic [1:0]  wen_q;
  logic [31:0] wdat0_q;
  logic [31:0] wdat1_q;
  logic [4:0]  vd_q;
  logic [4:0]  mem_vd;

  // ALU and config results go straight through
  assign pass_take = ex_valid && (ex_in.op == vmem_pipe_pkg::VOP_ALU ||
                                  ex_in.op == vmem_pipe_pkg::VOP_CONFIG);
  assign mem_take  = ex_valid && (ex_in.op == vmem_pipe_pkg::VOP_LOAD ||
                                  ex_in.op == vmem_pipe_pkg::VOP_STORE);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= 1'b0;
      wen_q   <= 2'b00;
    end else if (flush) begin
      valid_q <= 1'b0;
      wen_q   <= 2'b00;
    end else if (wb_load) begin
      valid_q <= 1'b1;
      wen_q   <= mem_wen;
    end else if (pass_take) begin
      valid_q <= 1'b1;
      wen_q   <= ex_in.wen;
    end else begin
      valid_q <= 1'b0;
      wen_q   <= 2'b00;
    end
  end

  always_ff @(posedge CLK) begin
    // Destination of the memory op in flight
    if (mem_take) begin
      mem_vd <= ex_in.vd;
    end
    if (wb_load) begin
      wdat0_q <= ldata0;
      wdat1_q <= ldata1;
      vd_q    <= mem_vd;
    end else if (pass_take) begin
      wdat0_q <= ex_in.result0;
      wdat1_q <= ex_in.result1;
      vd_q    <= ex_in.vd;
    end
  end

  // CSR fields follow the live registers
  always_comb begin
    wb_out.valid = valid_q;
    wb_out.wdat0 = wdat0_q;
    wb_out.wdat1 = wdat1_q;
    wb_out.wen   = wen_q;
    wb_out.vd    = vd_q;
    wb_out.sew   = vtype.sew;
    wb_out.lmul  = vtype.vlmul;
    wb_out.vl    = vl;
  end

endmodule

`default_nettype wire

// ==== vmem_stage_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module vmem_stage_top #(
  parameter int ADDR_W     = 10,
  parameter int DMEM_WORDS = 256
) (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    ex_valid,
  input  vmem_pipe_pkg::ex_mem_t  ex_in,
  input  logic                    flush,
  output vmem_pipe_pkg::mem_wb_t  wb_out,
  output logic                    busy,
  output logic                    exception
);

  vmem_pipe_pkg::dmem_req_t dmem_req;
  vmem_pipe_pkg::ex_mem_t   mem_inst;
  vmem_types_pkg::vtype_t   vtype;
  logic [31:0]              vl;
  logic [31:0]              rdata;
  logic [31:0]              fmt_data0;
  logic [31:0]              fmt_data1;
  logic [3:0]               fmt_be0;
  logic [3:0]               fmt_be1;
  logic [1:0]               misalign;
  logic [1:0]               mem_wen;
  logic                     load_lane0;
  logic                     load_lane1;
  logic                     wb_load;
  logic [31:0]              ldata0;
  logic [31:0]              ldata1;

  vmem_csr_regs u_csr (
    .CLK      (CLK),
    .nRST     (nRST),
    .ex_valid (ex_valid),
    .ex_in    (ex_in),
    .vl       (vl),
    .vtype    (vtype),
    .vstart   ()
  );

  vmem_addr_scheduler u_sched (
    .CLK        (CLK),
    .nRST       (nRST),
    .ex_valid   (ex_valid),
    .ex_in      (ex_in),
    .flush      (flush),
    .vl         (vl),
    .misalign   (misalign),
    .fmt_data0  (fmt_data0),
    .fmt_data1  (fmt_data1),
    .fmt_be0    (fmt_be0),
    .fmt_be1    (fmt_be1),
    .dmem_req   (dmem_req),
    .mem_inst   (mem_inst),
    .mem_wen    (mem_wen),
    .load_lane0 (load_lane0),
    .load_lane1 (load_lane1),
    .wb_load    (wb_load),
    .busy       (busy),
    .exception  (exception)
  );

  // Formatting works on the held instruction
  vmem_store_format u_fmt (
    .eew        (mem_inst.eew),
    .addr0      (mem_inst.result0[1:0]),
    .addr1      (mem_inst.result1[1:0]),
    .storedata0 (mem_inst.storedata0),
    .storedata1 (mem_inst.storedata1),
    .fmt_data0  (fmt_data0),
    .fmt_data1  (fmt_data1),
    .fmt_be0    (fmt_be0),
    .fmt_be1    (fmt_be1),
    .misalign   (misalign)
  );

  vmem_data_ram #(
    .ADDR_W     (ADDR_W),
    .DMEM_WORDS (DMEM_WORDS)
  ) u_ram (
    .CLK      (CLK),
    .nRST     (nRST),
    .dmem_req (dmem_req),
    .rdata    (rdata),
    .dhit     ()
  );

  vmem_load_align u_align (
    .CLK        (CLK),
    .nRST       (nRST),
    .rdata      (rdata),
    .load_lane0 (load_lane0),
    .load_lane1 (load_lane1),
    .eew        (mem_inst.eew),
    .addr0      (mem_inst.result0[1:0]),
    .addr1      (mem_inst.result1[1:0]),
    .ldata0     (ldata0),
    .ldata1     (ldata1)
  );

  vmem_wb_latch u_wb (
    .CLK      (CLK),
    .nRST     (nRST),
    .flush    (flush),
    .ex_valid (ex_valid),
    .ex_in    (ex_in),
    .wb_load  (wb_load),
    .ldata0   (ldata0),
    .ldata1   (ldata1),
    .mem_wen  (mem_wen),
    .vl       (vl),
    .vtype    (vtype),
    .wb_out   (wb_out)
  );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 2,
  parameter int RESET_CYCLES = 10
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  // Release reset away from the active edge
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_vmem_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_vmem_stage;

  localparam int RESET_CYCLES  = 10;
  // About 36 instructions of at most 6 cycles each, doubled for margin
  localparam int OP_COUNT      = 36;
  localparam int CYCLES_PER_OP = 6;
  localparam int CYCLE_LIMIT   = (RESET_CYCLES + OP_COUNT * CYCLES_PER_OP) * 2;

  typedef struct packed {
    int          due;
    logic [31:0] wdat0;
    logic [31:0] wdat1;
    logic [1:0]  wen;
    logic [1:0]  chk;
    logic [4:0]  vd;
  } exp_t;

  logic                    CLK;
  logic                    nRST;
  logic                    ex_valid;
  logic                    flush;
  vmem_pipe_pkg::ex_mem_t  ex_in;
  vmem_pipe_pkg::mem_wb_t  wb_out;
  logic                    busy;
  logic                    exception;

  // Reference model state
  logic [7:0]              model_mem [1024];
  logic [31:0]             model_vl;
  vmem_types_pkg::vtype_t  model_vtype;
  exp_t                    exp_q [$];
  exp_t                    exp_cur;
  logic                    exp_valid;
  logic                    exp_busy;
  logic                    exp_exc;
  int                      busy_from;
  int                      busy_to;
  int                      exc_at0;
  int                      exc_at1;
  int                      cyc;
  int                      err_count;
  int                      lost;
  int                      results;
  integer                  seed;

  tb_clock_gen #(.HALF_PERIOD(2), .RESET_CYCLES(RESET_CYCLES)) u_clk (
    .CLK  (CLK),
    .nRST (nRST)
  );

  vmem_stage_top #(.ADDR_W(10), .DMEM_WORDS(256)) u_vmem_stage_top (
    .CLK       (CLK),
    .nRST      (nRST),
    .ex_valid  (ex_valid),
    .ex_in     (ex_in),
    .flush     (flush),
    .wb_out    (wb_out),
    .busy      (busy),
    .exception (exception)
  );

  task automatic note_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    err_count++;
    $display("CHECK FAILED %s got %h expected %h at cycle %0d", name, got, want, cyc);
  endtask

  task automatic report_counts();
    $display("Errors: %0d  lost results: %0d  results checked: %0d  cycles: %0d",
             err_count, lost, results, cyc);
  endtask

  function automatic int nbytes(input vmem_types_pkg::sew_t w);
    case (w)
      vmem_types_pkg::SEW8:  return 1;
      vmem_types_pkg::SEW16: return 2;
      default:               return 4;
    endcase
  endfunction

  function automatic logic aligned(input vmem_types_pkg::sew_t w, input logic [31:0] a);
    case (w)
      vmem_types_pkg::SEW16: return ~a[0];
      vmem_types_pkg::SEW32: return (a[1:0] == 2'b00);
      default:               return 1'b1;
    endcase
  endfunction

  // Little endian element at a byte address, upper bytes zero
  function automatic logic [31:0] read_elem(input vmem_types_pkg::sew_t w,
                                            input logic [31:0] a);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < nbytes(w); k++) begin
      v[8*k +: 8] = model_mem[10'(a[9:0] + k)];
    end
    return v;
  endfunction

  task automatic write_elem(input vmem_types_pkg::sew_t w, input logic [31:0] a,
                            input logic [31:0] d);
    for (int k = 0; k < nbytes(w); k++) begin
      model_mem[10'(a[9:0] + k)] = d[8*k +: 8];
    end
  endtask

  // Predict the result, memory effect and timing of one strobed instruction
  task automatic accept(input vmem_pipe_pkg::ex_mem_t ins);
    exp_t       e;
    logic [1:0] act;
    logic [1:0] ok;
    e    = '0;
    e.vd = ins.vd;
    case (ins.op)
      vmem_pipe_pkg::VOP_ALU, vmem_pipe_pkg::VOP_CONFIG: begin
        e.due   = cyc;
        e.wdat0 = ins.result0;
        e.wdat1 = ins.result1;
        e.wen   = ins.wen;
        e.chk   = 2'b11;
        if (ins.op == vmem_pipe_pkg::VOP_CONFIG) begin
          model_vl    = (ins.next_vl > 32'd2) ? 32'd2 : ins.next_vl;
          model_vtype = ins.next_vtype;
        end
      end
      default: begin
        act       = {model_vl >= 32'd2, 1'b1};
        ok        = {aligned(ins.eew, ins.result1), aligned(ins.eew, ins.result0)};
        exc_at0   = ok[0] ? -1 : cyc;
        exc_at1   = (act[1] && !ok[1]) ? cyc + 1 : -1;
        busy_from = cyc;
        busy_to   = cyc + 3;
        e.due     = cyc + 3;
        if (ins.op == vmem_pipe_pkg::VOP_STORE) begin
          if (ok[0]) begin
            write_elem(ins.eew, ins.result0, ins.storedata0);
          end
          if (act[1] && ok[1]) begin
            write_elem(ins.eew, ins.result1, ins.storedata1);
          end
        end else begin
          e.wdat0 = read_elem(ins.eew, ins.result0);
          e.wdat1 = read_elem(ins.eew, ins.result1);
          e.chk   = act & ok;
          e.wen   = ins.wen & act & ok;
        end
      end
    endcase
    exp_q.push_back(e);
  endtask

  always @(posedge CLK) begin
    cyc++;
    if (cyc >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      report_counts();
      $display(">>> FAIL");
      $finish;
    end else begin
      if (nRST && flush) begin
        // Flushed results never reach writeback
        exp_q.delete();
        busy_to = cyc;
        exc_at0 = -1;
        exc_at1 = -1;
      end else if (nRST && ex_valid) begin
        accept(ex_in);
      end
      if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
        exp_cur   = exp_q.pop_front();
        exp_valid = 1'b1;
        results++;
      end else begin
        exp_cur   = '0;
        exp_valid = 1'b0;
      end
      exp_busy = (cyc >= busy_from) && (cyc < busy_to);
      exp_exc  = (cyc == exc_at0) || (cyc == exc_at1);
    end
  end

  // Outputs come from registers only, so the falling edge sees them settled
  assert property (@(negedge CLK) disable iff (!nRST) wb_out.valid == exp_valid)
    else note_mismatch("wb_out.valid", 32'(wb_out.valid), 32'(exp_valid));
  assert property (@(negedge CLK) disable iff (!nRST) wb_out.wen == exp_cur.wen)
    else note_mismatch("wb_out.wen", 32'(wb_out.wen), 32'(exp_cur.wen));
  assert property (@(negedge CLK) disable iff (!nRST)
                   !(exp_valid && exp_cur.chk[0]) || wb_out.wdat0 == exp_cur.wdat0)
    else note_mismatch("wb_out.wdat0", wb_out.wdat0, exp_cur.wdat0);
  assert property (@(negedge CLK) disable iff (!nRST)
                   !(exp_valid && exp_cur.chk[1]) || wb_out.wdat1 == exp_cur.wdat1)
    else note_mismatch("wb_out.wdat1", wb_out.wdat1, exp_cur.wdat1);
  assert property (@(negedge CLK) disable iff (!nRST) !exp_valid || wb_out.vd == exp_cur.vd)
    else note_mismatch("wb_out.vd", 32'(wb_out.vd), 32'(exp_cur.vd));
  assert property (@(negedge CLK) disable iff (!nRST) wb_out.vl == model_vl)
    else note_mismatch("wb_out.vl", wb_out.vl, model_vl);
  assert property (@(negedge CLK) disable iff (!nRST) wb_out.sew == model_vtype.sew)
    else note_mismatch("wb_out.sew", 32'(wb_out.sew), 32'(model_vtype.sew));
  assert property (@(negedge CLK) disable iff (!nRST) wb_out.lmul == model_vtype.vlmul)
    else note_mismatch("wb_out.lmul", 32'(wb_out.lmul), 32'(model_vtype.vlmul));
  assert property (@(negedge CLK) disable iff (!nRST) busy == exp_busy)
    else note_mismatch("busy", 32'(busy), 32'(exp_busy));
  assert property (@(negedge CLK) disable iff (!nRST) exception == exp_exc)
    else note_mismatch("exception", 32'(exception), 32'(exp_exc));

  function automatic vmem_pipe_pkg::ex_mem_t make_mem(input vmem_pipe_pkg::vop_t op,
      input vmem_types_pkg::sew_t w, input logic [31:0] a0, input logic [31:0] a1);
    vmem_pipe_pkg::ex_mem_t i;
    i            = '0;
    i.op         = op;
    i.eew        = w;
    i.result0    = a0;
    i.result1    = a1;
    i.storedata0 = $random(seed);
    i.storedata1 = $random(seed);
    i.wen        = 2'b11;
    i.vd         = 5'($random(seed));
    return i;
  endfunction

  function automatic vmem_pipe_pkg::ex_mem_t make_cfg(input logic [31:0] nvl,
      input vmem_types_pkg::sew_t w, input vmem_types_pkg::vlmul_t lm);
    vmem_pipe_pkg::ex_mem_t i;
    i                  = '0;
    i.op               = vmem_pipe_pkg::VOP_CONFIG;
    i.result0          = $random(seed);
    i.result1          = $random(seed);
    i.vd               = 5'($random(seed));
    i.next_vl          = nvl;
    i.next_vtype.sew   = w;
    i.next_vtype.vlmul = lm;
    return i;
  endfunction

  function automatic vmem_pipe_pkg::ex_mem_t make_alu();
    vmem_pipe_pkg::ex_mem_t i;
    i         = '0;
    i.op      = vmem_pipe_pkg::VOP_ALU;
    i.result0 = $random(seed);
    i.result1 = $random(seed);
    i.wen     = 2'($random(seed));
    i.vd      = 5'($random(seed));
    return i;
  endfunction

  task automatic drive(input vmem_pipe_pkg::ex_mem_t ins);
    @(negedge CLK);
    ex_in    = ins;
    ex_valid = 1'b1;
  endtask

  // Drop the strobe and wait for a memory op to finish
  task automatic settle();
    @(negedge CLK);
    ex_valid = 1'b0;
    while (busy) begin
      @(negedge CLK);
    end
  endtask

  task automatic run_op(input vmem_pipe_pkg::ex_mem_t ins);
    drive(ins);
    settle();
  endtask

  initial begin
    vmem_types_pkg::sew_t w;
    logic [31:0]          a0;
    ex_valid    = 1'b0;
    flush       = 1'b0;
    ex_in       = '0;
    seed        = 32'h6639;
    model_vl    = '0;
    model_vtype = '0;
    exp_cur     = '0;
    exp_valid   = 1'b0;
    exp_busy    = 1'b0;
    exp_exc     = 1'b0;
    busy_from   = 0;
    busy_to     = 0;
    exc_at0     = -1;
    exc_at1     = -1;
    cyc         = 0;
    err_count   = 0;
    lost        = 0;
    results     = 0;
    @(posedge nRST);
    repeat (2) @(negedge CLK);

    // Config with vl above the lane count, then an ALU burst
    run_op(make_cfg(32'd5, vmem_types_pkg::SEW16, vmem_types_pkg::LMUL_2));
    repeat (4) drive(make_alu());
    settle();
    run_op(make_cfg(32'd2, vmem_types_pkg::SEW32, vmem_types_pkg::LMUL_1));

    // Store then load back at every element width
    for (int t = 0; t < 8; t++) begin
      w  = vmem_types_pkg::sew_t'(2'(t % 3));
      a0 = 32'($random(seed)) & 32'h1FF & ~(32'(nbytes(w)) - 32'd1);
      run_op(make_mem(vmem_pipe_pkg::VOP_STORE, w, a0, a0 + 32'h200));
      run_op(make_mem(vmem_pipe_pkg::VOP_LOAD, w, a0, a0 + 32'h200));
    end

    // Lane 1 inactive with vl of 1
    run_op(make_mem(vmem_pipe_pkg::VOP_STORE, vmem_types_pkg::SEW32, 32'h040, 32'h240));
    run_op(make_cfg(32'd1, vmem_types_pkg::SEW32, vmem_types_pkg::LMUL_1));
    run_op(make_mem(vmem_pipe_pkg::VOP_STORE, vmem_types_pkg::SEW32, 32'h040, 32'h240));
    run_op(make_mem(vmem_pipe_pkg::VOP_LOAD, vmem_types_pkg::SEW32, 32'h040, 32'h240));
    run_op(make_cfg(32'd2, vmem_types_pkg::SEW32, vmem_types_pkg::LMUL_1));
    run_op(make_mem(vmem_pipe_pkg::VOP_LOAD, vmem_types_pkg::SEW32, 32'h040, 32'h240));

    // Misaligned lanes on stores and loads
    run_op(make_mem(vmem_pipe_pkg::VOP_STORE, vmem_types_pkg::SEW32, 32'h080, 32'h280));
    run_op(make_mem(vmem_pipe_pkg::VOP_STORE, vmem_types_pkg::SEW16, 32'h081, 32'h282));
    run_op(make_mem(vmem_pipe_pkg::VOP_STORE, vmem_types_pkg::SEW32, 32'h084, 32'h282));
    run_op(make_mem(vmem_pipe_pkg::VOP_LOAD, vmem_types_pkg::SEW32, 32'h080, 32'h280));
    run_op(make_mem(vmem_pipe_pkg::VOP_LOAD, vmem_types_pkg::SEW32, 32'h082, 32'h280));
    run_op(make_mem(vmem_pipe_pkg::VOP_LOAD, vmem_types_pkg::SEW16, 32'h080, 32'h281));

    // Flush lands in the cycle before the load result is due
    drive(make_mem(vmem_pipe_pkg::VOP_LOAD, vmem_types_pkg::SEW32, 32'h040, 32'h240));
    @(negedge CLK);
    ex_valid = 1'b0;
    @(negedge CLK);
    @(negedge CLK);
    flush = 1'b1;
    @(negedge CLK);
    flush = 1'b0;
    settle();
    run_op(make_mem(vmem_pipe_pkg::VOP_LOAD, vmem_types_pkg::SEW32, 32'h080, 32'h280));

    repeat (3) @(negedge CLK);
    if (exp_q.size() != 0) begin
      lost = exp_q.size();
      $display("Expected results never appeared on wb_out: %0d", lost);
    end
    report_counts();
    if (err_count == 0 && lost == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
vmem_types_pkg.sv
vmem_pipe_pkg.sv
vmem_store_format.sv
vmem_load_align.sv
vmem_addr_scheduler.sv
vmem_csr_regs.sv
vmem_data_ram.sv
vmem_wb_latch.sv
vmem_stage_top.sv
tb_clock_gen.sv
tb_vmem_stage.sv

// ==== Makefile ====
# Verilator simulation of the vector memory stage

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench, then check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f build.f --top-module tb_vmem_stage -Mdir obj_dir
	./obj_dir/Vtb_vmem_stage | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
